// File: project.f
+incdir+hdl
hdl/mpu_pkg.sv
hdl/mpu_io_fabric.sv
hdl/mpu_pit.sv
hdl/mpu_pic.sv
hdl/mpu_top.sv
sim/mpu_assert.sv
sim/tb_mpu.sv

// File: Makefile
# verilator build and run of tb_mpu
# the run only passes when the log holds the pass line

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_mpu -f project.f -Mdir obj_dir -o tb_mpu

run: compile
	./obj_dir/tb_mpu | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_mpu.sv
// testbench for the i/o subsystem, acts as bus master and pin driver, timer latency is only waited out
`timescale 1ns/100ps
`include "mpu_defs.svh"

module tb_mpu;

	import mpu_pkg::*;

	// ==========================================================
	// run length
	// ==========================================================

	localparam int N_REG   = 32;
	localparam int N_UNMAP = 16;
	localparam int N_IRQ   = 16;
	// six timer phases per channel across expiry and auto-reload
	localparam int NUM_OPS = N_REG + N_UNMAP + N_IRQ + 6 * `MPU_PIT_CHANNELS;
	// worst op is a timer phase, up to 9 ticks of 16 cycles plus bus traffic
	localparam int CYCLES_PER_OP = 200;
	// 4 ns clock, twice the estimate as margin
	localparam int WATCHDOG_NS   = NUM_OPS * CYCLES_PER_OP * 4 * 2;

	logic                         clk;
	logic                         arst_n;
	logic                         req_stb;
	logic                         req_we;
	addr_t                        req_adr;
	word_t                        req_dat;
	logic                         resp_ack;
	logic                         resp_err;
	word_t                        resp_dat;
	word_t                        irq_bus;
	logic [`MPU_PIT_CHANNELS-1:0] tmr_clk;
	logic [`MPU_PIT_CHANNELS-1:0] tmr_gate;
	logic [`MPU_PIT_CHANNELS-1:0] tmr_out;
	logic                         irq;
	irq_src_t                     cause;

	// reference model state
	word_t                        en_m;
	word_t                        pend_m;
	word_t                        reload_m [`MPU_PIT_CHANNELS];
	word_t                        count_m [`MPU_PIT_CHANNELS];
	pit_ctrl_t                    ctrl_m [`MPU_PIT_CHANNELS];
	logic [`MPU_PIT_CHANNELS-1:0] out_m;

	int          word_errs = 0;
	int          bit_errs = 0;
	int          cause_errs = 0;
	logic [15:0] lfsr_q = 16'd50060;

	mpu_top u_dut
	(
		.clk_i      (clk),
		.arst_n_i   (arst_n),
		.req_stb_i  (req_stb),
		.req_we_i   (req_we),
		.req_adr_i  (req_adr),
		.req_dat_i  (req_dat),
		.resp_ack_o (resp_ack),
		.resp_err_o (resp_err),
		.resp_dat_o (resp_dat),
		.irq_bus_i  (irq_bus),
		.tmr_clk_i  (tmr_clk),
		.tmr_gate_i (tmr_gate),
		.tmr_out_o  (tmr_out),
		.irq_o      (irq),
		.cause_o    (cause)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	// ==========================================================
	// random numbers and expected values
	// ==========================================================

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic rand_bit();
		logic b;
		b = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], b};
		return b;
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], rand_bit()};
		return v;
	endfunction

	// highest enabled pending source wins, zero when none
	function automatic irq_src_t top_source(input word_t act);
		for (int i = `MPU_PIC_SOURCES - 1; i > 0; i--)
			if (act[i])
				return irq_src_t'(i);
		return '0;
	endfunction

	// reserved control bits are not stored and read back zero
	function automatic pit_ctrl_t ctrl_bits(input pit_word_u w);
		pit_ctrl_t c;
		c      = w.ctrl;
		c.rsvd = '0;
		return c;
	endfunction

	function automatic addr_t pit_adr(input int ch, input logic ctl);
		return {`MPU_IO_BASE, 8'h00, `MPU_PIT_BLOCK, 12'(ch * 8 + (ctl ? 4 : 0))};
	endfunction

	function automatic addr_t pic_adr(input logic [11:0] ofs);
		return {`MPU_IO_BASE, 8'h00, `MPU_PIC_BLOCK, ofs};
	endfunction

	// ==========================================================
	// compare tasks
	// ==========================================================

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			word_errs++;
			$display("** Error %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			bit_errs++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_cause(input string name, input irq_src_t exp, input irq_src_t act);
		if (act !== exp)
		begin
			cause_errs++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// ==========================================================
	// bus and pin drivers
	// ==========================================================

	// wait n edges then sample mid-cycle
	task automatic settle(input int n);
		repeat (n) @(posedge clk);
		@(negedge clk);
	endtask

	// one strobe, response checked one cycle later
	task automatic bus_access(input string name, input logic we, input addr_t adr,
		input word_t dat, output word_t rd, output logic err);
		@(posedge clk);
		req_stb <= 1'b1;
		req_we  <= we;
		req_adr <= adr;
		req_dat <= dat;
		@(negedge clk);
		// no ack before this strobe is taken
		check_bit($sformatf("%s idle ack", name), 1'b0, resp_ack);
		@(posedge clk);
		req_stb <= 1'b0;
		@(negedge clk);
		check_bit($sformatf("%s ack", name), 1'b1, resp_ack);
		rd  = resp_dat;
		err = resp_err;
	endtask

	task automatic write_reg(input string name, input addr_t adr, input word_t dat);
		word_t rd;
		logic  err;
		bus_access(name, 1'b1, adr, dat, rd, err);
		check_bit($sformatf("%s err", name), 1'b0, err);
	endtask

	task automatic read_reg(input string name, input addr_t adr, output word_t rd);
		logic err;
		bus_access(name, 1'b0, adr, '0, rd, err);
		check_bit($sformatf("%s err", name), 1'b0, err);
	endtask

	task automatic set_enable(input string name, input word_t v);
		write_reg(name, pic_adr(12'h000), v);
		en_m = v;
	endtask

	task automatic set_ctrl(input int k, input pit_word_u w);
		write_reg("ctrl write", pit_adr(k, 1'b1), w.count);
		ctrl_m[k] = ctrl_bits(w);
	endtask

	// a reload write loads the counter as well
	task automatic load_reload(input int k, input word_t v);
		write_reg("reload write", pit_adr(k, 1'b0), v);
		reload_m[k] = v;
		count_m[k]  = v;
	endtask

	task automatic check_irq_state(input string name);
		check_bit($sformatf("%s irq", name), |(pend_m & en_m), irq);
		check_cause($sformatf("%s cause", name), top_source(pend_m & en_m), cause);
	endtask

	task automatic clear_pending(input string name, input word_t mask);
		write_reg(name, pic_adr(12'h008), mask);
		pend_m = pend_m & ~mask;
		settle(2);
		check_irq_state(name);
	endtask

	task automatic pulse_irq(input int s);
		@(posedge clk);
		irq_bus <= word_t'(1) << s;
		@(posedge clk);
		irq_bus <= '0;
	endtask

	// one external clock period, each phase 8 cycles
	task automatic tick(input int k);
		@(posedge clk);
		tmr_clk[k] <= 1'b1;
		repeat (8) @(posedge clk);
		tmr_clk[k] <= 1'b0;
		repeat (7) @(posedge clk);
	endtask

	// count, output pin, pending bit and request after a run of ticks
	// an expiry toggles the pin and raises the channel's source
	task automatic timer_expect(input string name, input int k, input logic fired);
		word_t rd;
		read_reg(name, pit_adr(k, 1'b0), rd);
		check_word($sformatf("%s count ch%0d", name, k), count_m[k], rd);
		if (fired)
		begin
			out_m[k]                      = ~out_m[k];
			pend_m[`MPU_PIT_SRC_BASE + k] = 1'b1;
		end
		check_bit($sformatf("%s tmr_out ch%0d", name, k), out_m[k], tmr_out[k]);
		read_reg(name, pic_adr(12'h004), rd);
		check_word($sformatf("%s pending", name), pend_m, rd);
		check_irq_state(name);
		if (fired)
			clear_pending(name, word_t'(1) << (`MPU_PIT_SRC_BASE + k));
	endtask

	// ==========================================================
	// tests
	// ==========================================================

	task automatic regs_readback();
		pit_word_u wv;
		word_t     rd;
		int        kind;
		int        ch;
		for (int n = 0; n < N_REG; n++)
		begin
			kind     = int'(rand_bits(2));
			ch       = int'(rand_bits(2));
			wv.count = rand_bits(32);
			case (kind)
			0:
			begin
				set_enable("enable write", wv.count);
				read_reg("enable read", pic_adr(12'h000), rd);
				check_word("enable read", en_m, rd);
			end
			1:
			begin
				// count view of the written word
				load_reload(ch, wv.count);
				read_reg("count read", pit_adr(ch, 1'b0), rd);
				check_word("count read", count_m[ch], rd);
			end
			2:
			begin
				// ctrl view of the written word
				set_ctrl(ch, wv);
				read_reg("ctrl read", pit_adr(ch, 1'b1), rd);
				check_word("ctrl read", word_t'(ctrl_m[ch]), rd);
			end
			default:
			begin
				read_reg("pending read", pic_adr(12'h004), rd);
				check_word("pending read", pend_m, rd);
				read_reg("cause read", pic_adr(12'h00C), rd);
				check_word("cause read", word_t'(top_source(pend_m & en_m)), rd);
			end
			endcase
		end
	endtask

	task automatic unmapped_access();
		addr_t      adr;
		word_t      rd;
		logic       err;
		logic [3:0] blk;
		for (int n = 0; n < N_UNMAP; n++)
		begin
			adr = rand_bits(32);
			if (rand_bit())
			begin
				// outside the window
				if (adr[31:24] == `MPU_IO_BASE)
					adr[31:24] = ~adr[31:24];
			end
			else
			begin
				// inside the window with a block code nothing answers to
				blk = 4'(rand_bits(4));
				if (blk == `MPU_PIT_BLOCK || blk == `MPU_PIC_BLOCK)
					blk = 4'hF;
				adr[31:24] = `MPU_IO_BASE;
				adr[15:12] = blk;
			end
			bus_access("unmapped", rand_bit(), adr, rand_bits(32), rd, err);
			check_bit("unmapped err", 1'b1, err);
			check_word("unmapped data", '0, rd);
		end
		// mapped registers untouched
		read_reg("enable after unmapped", pic_adr(12'h000), rd);
		check_word("enable after unmapped", en_m, rd);
		for (int k = 0; k < `MPU_PIT_CHANNELS; k++)
		begin
			read_reg("count after unmapped", pit_adr(k, 1'b0), rd);
			check_word("count after unmapped", count_m[k], rd);
			read_reg("ctrl after unmapped", pit_adr(k, 1'b1), rd);
			check_word("ctrl after unmapped", word_t'(ctrl_m[k]), rd);
		end
	endtask

	task automatic ext_interrupts();
		word_t rd;
		word_t mask;
		int    s;
		clear_pending("irq setup", '1);
		set_enable("irq enable", rand_bits(32));
		for (int n = 0; n < N_IRQ; n++)
		begin
			// external sources 1..27, the top four belong to the timer
			s = int'(rand_bits(5) % (`MPU_PIT_SRC_BASE - 1)) + 1;
			pulse_irq(s);
			pend_m[s] = 1'b1;
			settle(4);
			read_reg("irq pending", pic_adr(12'h004), rd);
			check_word("irq pending", pend_m, rd);
			check_irq_state("irq raise");
			read_reg("irq cause reg", pic_adr(12'h00C), rd);
			check_word("irq cause reg", word_t'(top_source(pend_m & en_m)), rd);
			if (rand_bit())
				clear_pending("irq clear", rand_bits(32));
			if (rand_bits(2) == '0)
				set_enable("irq re-enable", rand_bits(32));
		end
		clear_pending("irq done", '1);
		// only the timer sources stay enabled
		mask = '0;
		mask[`MPU_PIT_SRC_BASE +: `MPU_PIT_CHANNELS] = '1;
		set_enable("timer enable", mask);
	endtask

	task automatic timer_expiry();
		pit_word_u wv;
		word_t     rd;
		int        r;
		for (int k = 0; k < `MPU_PIT_CHANNELS; k++)
		begin
			r              = 2 + int'(rand_bits(3));
			wv             = '0;
			wv.ctrl.enable = 1'b1;
			set_ctrl(k, wv);
			load_reload(k, word_t'(r));
			repeat (r - 1)
				tick(k);
			read_reg("count before expiry", pit_adr(k, 1'b0), rd);
			check_word("count before expiry", word_t'(1), rd);
			tick(k);
			count_m[k] = '0;
			timer_expect("expiry", k, 1'b1);
			// gate held low stops the count
			wv.ctrl.gate_en = 1'b1;
			set_ctrl(k, wv);
			load_reload(k, word_t'(r));
			repeat (r)
				tick(k);
			timer_expect("gated", k, 1'b0);
		end
	endtask

	task automatic auto_reload();
		pit_word_u wv;
		int        r;
		for (int k = 0; k < `MPU_PIT_CHANNELS; k++)
		begin
			r                   = 2 + int'(rand_bits(3));
			wv                  = '0;
			wv.ctrl.enable      = 1'b1;
			wv.ctrl.auto_reload = 1'b1;
			set_ctrl(k, wv);
			load_reload(k, word_t'(r));
			repeat (r)
				tick(k);
			// expiry puts the reload value back
			count_m[k] = reload_m[k];
			timer_expect("auto-reload first", k, 1'b1);
			repeat (r)
				tick(k);
			timer_expect("auto-reload second", k, 1'b1);
			// one-shot, stops at zero
			wv.ctrl.auto_reload = 1'b0;
			set_ctrl(k, wv);
			load_reload(k, word_t'(r));
			repeat (r)
				tick(k);
			count_m[k] = '0;
			timer_expect("one-shot", k, 1'b1);
			repeat (2)
				tick(k);
			timer_expect("one-shot stopped", k, 1'b0);
		end
	endtask

	// ==========================================================
	// sequence and verdict
	// ==========================================================

	initial
	begin
		arst_n   = 1'b0;
		req_stb  = 1'b0;
		req_we   = 1'b0;
		req_adr  = '0;
		req_dat  = '0;
		irq_bus  = '0;
		tmr_clk  = '0;
		tmr_gate = '0;
		en_m     = '0;
		pend_m   = '0;
		out_m    = '0;
		for (int k = 0; k < `MPU_PIT_CHANNELS; k++)
		begin
			reload_m[k] = '0;
			count_m[k]  = '0;
			ctrl_m[k]   = '0;
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		settle(2);
		// quiet outputs out of reset
		check_bit("reset ack", 1'b0, resp_ack);
		check_bit("reset err", 1'b0, resp_err);
		check_bit("reset irq", 1'b0, irq);
		check_cause("reset cause", '0, cause);
		check_word("reset tmr_out", '0, word_t'(tmr_out));
		regs_readback();
		unmapped_access();
		ext_interrupts();
		timer_expiry();
		auto_reload();
		$display("errors: %0d word, %0d bit, %0d cause, %0d assertion", word_errs, bit_errs,
			cause_errs, u_dut.u_assert.fail_cnt);
		if (word_errs + bit_errs + cause_errs + u_dut.u_assert.fail_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: sim/mpu_assert.sv
// bus timing and interrupt checks bound into the top level, blind to register contents
`timescale 1ns/100ps
`include "mpu_defs.svh"

module mpu_assert
(
	input logic                          clk_i,
	input logic                          arst_n_i,
	input logic                          req_stb_i,
	input logic                          resp_ack_i,
	input logic                          resp_err_i,
	input logic                          pit_stb_i,
	input logic                          pic_stb_i,
	input logic                          irq_i,
	input mpu_pkg::irq_src_t             cause_i,
	input logic [`MPU_PIT_CHANNELS-1:0] tmr_out_i
);

	// failed assertions, summed into the testbench verdict
	int fail_cnt = 0;

	// ==========================================================
	// bus handshake
	// ==========================================================

	// every strobe is answered on the next edge
	a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		req_stb_i |=> resp_ack_i)
		else
		begin
			fail_cnt++;
			$error("ack missing one cycle after a strobe");
		end

	// and nothing is answered without one
	a_no_stray_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		resp_ack_i |-> $past(req_stb_i))
		else
		begin
			fail_cnt++;
			$error("ack without a strobe in the cycle before");
		end

	// error only travels with an ack
	a_err_with_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		resp_err_i |-> resp_ack_i)
		else
		begin
			fail_cnt++;
			$error("error flag raised without an ack");
		end

	// ==========================================================
	// interrupts and reset
	// ==========================================================

	a_irq_has_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		irq_i |-> (cause_i != '0))
		else
		begin
			fail_cnt++;
			$error("irq raised with cause zero");
		end

	// first edge after reset release sees every output quiet
	a_quiet_after_reset: assert property (@(posedge clk_i)
		$rose(arst_n_i) |-> (!resp_ack_i && !resp_err_i && !irq_i && (tmr_out_i == '0)
			&& !pit_stb_i && !pic_stb_i))
		else
		begin
			fail_cnt++;
			$error("outputs not quiet after reset");
		end

endmodule

bind mpu_top mpu_assert u_assert
(
	.clk_i      (clk_i),
	.arst_n_i   (arst_n_i),
	.req_stb_i  (req_stb_i),
	.resp_ack_i (resp_ack_o),
	.resp_err_i (resp_err_o),
	.pit_stb_i  (pit_stb),
	.pic_stb_i  (pic_stb),
	.irq_i      (irq_o),
	.cause_i    (cause_o),
	.tmr_out_i  (tmr_out_o)
);

// File: hdl/mpu_top.sv
// i/o subsystem top, single-cycle strobe bus with no back-pressure, one response per strobe
`timescale 1ns/100ps
`include "mpu_defs.svh"

module mpu_top
(
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	// bus request
	input  logic                          req_stb_i,
	input  logic                          req_we_i,
	input  mpu_pkg::addr_t                req_adr_i,
	input  mpu_pkg::word_t                req_dat_i,
	// bus response
	output logic                          resp_ack_o,
	output logic                          resp_err_o,
	output mpu_pkg::word_t                resp_dat_o,
	// external interrupts and timer pins
	input  logic [`MPU_PIC_SOURCES-1:0]  irq_bus_i,
	input  logic [`MPU_PIT_CHANNELS-1:0] tmr_clk_i,
	input  logic [`MPU_PIT_CHANNELS-1:0] tmr_gate_i,
	output logic [`MPU_PIT_CHANNELS-1:0] tmr_out_o,
	// to the processor
	output logic                          irq_o,
	output mpu_pkg::irq_src_t             cause_o
);

	import mpu_pkg::*;

	logic                         pit_stb;
	logic                         pic_stb;
	word_t                        pit_rdat;
	word_t                        pic_rdat;
	logic [`MPU_PIT_CHANNELS-1:0] timer_irq;

	// ==========================================================
	// decode and response
	// ==========================================================

	mpu_io_fabric u_fabric
	(
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.req_stb_i  (req_stb_i),
		.req_we_i   (req_we_i),
		.req_adr_i  (req_adr_i),
		.pit_stb_o  (pit_stb),
		.pic_stb_o  (pic_stb),
		.pit_rdat_i (pit_rdat),
		.pic_rdat_i (pic_rdat),
		.resp_ack_o (resp_ack_o),
		.resp_err_o (resp_err_o),
		.resp_dat_o (resp_dat_o)
	);

	// ==========================================================
	// blocks
	// ==========================================================

	// both blocks see the low 12 address bits as offset
	mpu_pit u_pit
	(
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.stb_i       (pit_stb),
		.we_i        (req_we_i),
		.ofs_i       (req_adr_i[11:0]),
		.wdat_i      (req_dat_i),
		.rdat_o      (pit_rdat),
		.tmr_clk_i   (tmr_clk_i),
		.tmr_gate_i  (tmr_gate_i),
		.tmr_out_o   (tmr_out_o),
		.timer_irq_o (timer_irq)
	);

	mpu_pic u_pic
	(
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.stb_i       (pic_stb),
		.we_i        (req_we_i),
		.ofs_i       (req_adr_i[11:0]),
		.wdat_i      (req_dat_i),
		.rdat_o      (pic_rdat),
		.ext_irq_i   (irq_bus_i),
		.timer_irq_i (timer_irq),
		.irq_o       (irq_o),
		.cause_o     (cause_o)
	);

endmodule

// File: hdl/mpu_pic.sv
// interrupt controller, edge triggered only, source 0 never raises, no priority levels beyond number
`timescale 1ns/100ps
`include "mpu_defs.svh"

module mpu_pic
(
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [11:0]                   ofs_i,
	input  mpu_pkg::word_t                wdat_i,
	output mpu_pkg::word_t                rdat_o,
	input  logic [`MPU_PIC_SOURCES-1:0]  ext_irq_i,
	input  logic [`MPU_PIT_CHANNELS-1:0] timer_irq_i,
	output logic                          irq_o,
	output mpu_pkg::irq_src_t             cause_o
);

	import mpu_pkg::*;

	logic [`MPU_PIC_SOURCES-1:0] src_w;
	logic [`MPU_PIC_SOURCES-1:0] src_q;
	logic [`MPU_PIC_SOURCES-1:0] rise_q;
	logic [`MPU_PIC_SOURCES-1:0] enable_q;
	logic [`MPU_PIC_SOURCES-1:0] pending_q;
	logic [`MPU_PIC_SOURCES-1:0] active;
	logic [`MPU_PIC_SOURCES-1:0] clr_mask;
	logic                        ofs_hit;
	logic                        wr_en;
	logic                        wr_clr;
	irq_src_t                    cause_d;

	// ==========================================================
	// source merge and edge detect
	// ==========================================================

	// timer pulses land on the top sources
	always_comb
	begin
		src_w = ext_irq_i;
		src_w[`MPU_PIT_SRC_BASE +: `MPU_PIT_CHANNELS] =
			ext_irq_i[`MPU_PIT_SRC_BASE +: `MPU_PIT_CHANNELS] | timer_irq_i;
		// source 0 means "none"
		src_w[0] = 1'b0;
	end

	// registered rising edge
	always_ff @(posedge clk_i or negedge arst_n_i)
	if (!arst_n_i)
	begin
		src_q  <= '0;
		rise_q <= '0;
	end
	else
	begin
		src_q  <= src_w;
		rise_q <= src_w & ~src_q;
	end

	// ==========================================================
	// register access
	// ==========================================================

	// four words at 0, 4, 8 and C
	assign ofs_hit = (ofs_i[11:4] == '0) && (ofs_i[1:0] == 2'b00);
	assign wr_en   = stb_i && we_i && ofs_hit && (ofs_i[3:2] == 2'd0);
	assign wr_clr  = stb_i && we_i && ofs_hit && (ofs_i[3:2] == 2'd2);

	// write-one-to-clear mask
	assign clr_mask = wr_clr ? wdat_i : '0;

	// enable holds all 32 bits as written
	// a new edge wins over a clear in the same cycle
	always_ff @(posedge clk_i or negedge arst_n_i)
	if (!arst_n_i)
	begin
		enable_q  <= '0;
		pending_q <= '0;
	end
	else
	begin
		if (wr_en)
			enable_q <= wdat_i;
		pending_q <= (pending_q & ~clr_mask) | rise_q;
	end

	// read mux, clear reads back zero
	always_comb
	begin
		rdat_o = '0;
		if (ofs_hit)
		begin
			case (ofs_i[3:2])
			2'd0: rdat_o = enable_q;
			2'd1: rdat_o = pending_q;
			2'd3: rdat_o = word_t'(cause_o);
			default: rdat_o = '0;
			endcase
		end
	end

	// ==========================================================
	// request and cause
	// ==========================================================

	assign active = pending_q & enable_q;

	// highest numbered active source
	// bit 0 is skipped, it can never be pending
	always_comb
	begin
		cause_d = '0;
		for (int i = 1; i < `MPU_PIC_SOURCES; i++)
			if (active[i])
				cause_d = irq_src_t'(i);
	end

	// irq and cause move together so they always agree
	always_ff @(posedge clk_i or negedge arst_n_i)
	if (!arst_n_i)
	begin
		irq_o   <= 1'b0;
		cause_o <= '0;
	end
	else
	begin
		irq_o   <= |active;
		cause_o <= cause_d;
	end

endmodule

// File: hdl/mpu_pit.sv
// interval timer, channel k at offsets 8k and 8k+4, external clocks are slow against clk_i
`timescale 1ns/100ps
`include "mpu_defs.svh"

module mpu_pit
(
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [11:0]                   ofs_i,
	input  mpu_pkg::word_t                wdat_i,
	output mpu_pkg::word_t                rdat_o,
	input  logic [`MPU_PIT_CHANNELS-1:0] tmr_clk_i,
	input  logic [`MPU_PIT_CHANNELS-1:0] tmr_gate_i,
	output logic [`MPU_PIT_CHANNELS-1:0] tmr_out_o,
	output logic [`MPU_PIT_CHANNELS-1:0] timer_irq_o
);

	import mpu_pkg::*;

	localparam int CH_W = $clog2(`MPU_PIT_CHANNELS);

	pit_word_u                    wd;
	pit_ctrl_t                    ctrl_wr;
	logic                         ofs_hit;
	logic                         wr_hit;
	logic [CH_W-1:0]              ch_sel;
	logic [`MPU_PIT_CHANNELS-1:0] clk_s1, clk_s2, clk_s3;
	logic [`MPU_PIT_CHANNELS-1:0] gate_s1, gate_s2;
	logic [`MPU_PIT_CHANNELS-1:0] clk_rise;
	word_t                        count_rd [`MPU_PIT_CHANNELS];
	pit_ctrl_t                    ctrl_rd [`MPU_PIT_CHANNELS];

	// ==========================================================
	// register decode
	// ==========================================================

	// 8 bytes per channel, anything above the last channel reads zero
	assign ofs_hit = (ofs_i[11:3+CH_W] == '0) && (ofs_i[1:0] == 2'b00);
	assign ch_sel  = ofs_i[3 +: CH_W];
	assign wr_hit  = stb_i && we_i && ofs_hit;

	// written word, decoded by offset into count or ctrl
	assign wd = wdat_i;

	// keep only the defined control bits
	always_comb
	begin
		ctrl_wr             = '0;
		ctrl_wr.enable      = wd.ctrl.enable;
		ctrl_wr.auto_reload = wd.ctrl.auto_reload;
		ctrl_wr.gate_en     = wd.ctrl.gate_en;
	end

	// read mux
	// ofs bit 2 picks control over count
	always_comb
	begin
		rdat_o = '0;
		if (ofs_hit)
			rdat_o = ofs_i[2] ? word_t'(ctrl_rd[ch_sel]) : count_rd[ch_sel];
	end

	// ==========================================================
	// external clock and gate synchronizers
	// ==========================================================

	always_ff @(posedge clk_i or negedge arst_n_i)
	if (!arst_n_i)
	begin
		clk_s1  <= '0;
		clk_s2  <= '0;
		clk_s3  <= '0;
		gate_s1 <= '0;
		gate_s2 <= '0;
	end
	else
	begin
		clk_s1  <= tmr_clk_i;
		clk_s2  <= clk_s1;
		clk_s3  <= clk_s2;
		gate_s1 <= tmr_gate_i;
		gate_s2 <= gate_s1;
	end

	// one-cycle rise of each synchronized clock
	assign clk_rise = clk_s2 & ~clk_s3;

	// ==========================================================
	// channels
	// ==========================================================

	for (genvar k = 0; k < `MPU_PIT_CHANNELS; k++)
	begin : g_ch
		pit_ctrl_t ctrl_q;
		word_t     reload_q;
		word_t     count_q;
		logic      wr_reload;
		logic      wr_ctrl;
		logic      tick;
		logic      expire;
		logic      out_q;
		logic      irq_q;

		assign wr_reload = wr_hit && (ch_sel == CH_W'(k)) && !ofs_i[2];
		assign wr_ctrl   = wr_hit && (ch_sel == CH_W'(k)) && ofs_i[2];

		// count only when enabled and, with gate-enable, while the gate is high
		assign tick = clk_rise[k] && ctrl_q.enable && (!ctrl_q.gate_en || gate_s2[k]);

		// step from 1 to 0, a reload write in the same cycle takes precedence
		assign expire = tick && !wr_reload && (count_q == word_t'(1));

		always_ff @(posedge clk_i or negedge arst_n_i)
		if (!arst_n_i)
		begin
			ctrl_q  <= '0;
			count_q <= '0;
			out_q   <= 1'b0;
			irq_q   <= 1'b0;
		end
		else
		begin
			irq_q <= expire;
			if (wr_ctrl)
				ctrl_q <= ctrl_wr;
			// reload write loads the counter too
			if (wr_reload)
				count_q <= wd.count;
			else if (expire)
				count_q <= ctrl_q.auto_reload ? reload_q : '0;
			else if (tick && (count_q != '0))
				count_q <= count_q - word_t'(1);
			if (expire)
				out_q <= ~out_q;
		end

		always_ff @(posedge clk_i)
		if (wr_reload)
			reload_q <= wd.count;

		assign count_rd[k]    = count_q;
		assign ctrl_rd[k]     = ctrl_q;
		assign tmr_out_o[k]   = out_q;
		assign timer_irq_o[k] = irq_q;
	end

endmodule

// File: hdl/mpu_io_fabric.sv
// i/o fabric, adr[23:16] is not decoded and every strobe gets exactly one response next cycle
`timescale 1ns/100ps
`include "mpu_defs.svh"

module mpu_io_fabric
(
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  logic          req_stb_i,
	input  logic          req_we_i,
	input  mpu_pkg::addr_t req_adr_i,
	output logic          pit_stb_o,
	output logic          pic_stb_o,
	input  mpu_pkg::word_t pit_rdat_i,
	input  mpu_pkg::word_t pic_rdat_i,
	output logic          resp_ack_o,
	output logic          resp_err_o,
	output mpu_pkg::word_t resp_dat_o
);

	import mpu_pkg::*;

	logic  win_hit;
	logic  pit_sel;
	logic  pic_sel;
	word_t dat_d;

	// window and block decode
	assign win_hit = (req_adr_i[31:24] == `MPU_IO_BASE);
	assign pit_sel = win_hit && (req_adr_i[15:12] == `MPU_PIT_BLOCK);
	assign pic_sel = win_hit && (req_adr_i[15:12] == `MPU_PIC_BLOCK);

	// at most one block sees the strobe
	assign pit_stb_o = req_stb_i && pit_sel;
	assign pic_stb_o = req_stb_i && pic_sel;

	// read data mux
	// write responses and unmapped accesses carry zero data
	always_comb
	begin
		dat_d = '0;
		if (!req_we_i && pit_sel)
			dat_d = pit_rdat_i;
		else if (!req_we_i && pic_sel)
			dat_d = pic_rdat_i;
	end

	// ack and error, one cycle after the strobe
	always_ff @(posedge clk_i or negedge arst_n_i)
	if (!arst_n_i)
	begin
		resp_ack_o <= 1'b0;
		resp_err_o <= 1'b0;
	end
	else
	begin
		resp_ack_o <= req_stb_i;
		// nothing mapped at this address
		resp_err_o <= req_stb_i && !(pit_sel || pic_sel);
	end

	// response data only moves on a strobe
	always_ff @(posedge clk_i)
	if (req_stb_i)
		resp_dat_o <= dat_d;

endmodule

// File: hdl/mpu_pkg.sv
// shared bus and timer types, all 32-bit, the timer union only overlays one written data word
`include "mpu_defs.svh"

package mpu_pkg;

	// ==========================================================
	// bus words
	// ==========================================================

	// bus data word
	typedef logic [31:0] word_t;

	// bus address
	typedef logic [31:0] addr_t;

	// interrupt source number
	// zero doubles as "no source" since source 0 never raises
	typedef logic [$clog2(`MPU_PIC_SOURCES)-1:0] irq_src_t;

	// ==========================================================
	// timer register views
	// ==========================================================

	// channel control word
	// bit 0 enable, bit 1 auto-reload, bit 2 gate-enable
	typedef struct packed {
		logic [28:0] rsvd;
		logic        gate_en;
		logic        auto_reload;
		logic        enable;
	} pit_ctrl_t;

	// one written word seen two ways
	// count view for the reload register, ctrl view for the control register
	typedef union packed {
		word_t     count;
		pit_ctrl_t ctrl;
	} pit_word_u;

endpackage

// File: hdl/mpu_defs.svh
// i/o map constants, block codes live in address bits 15..12 and only two blocks are decoded
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// ==========================================================
// i/o window
// ==========================================================

// upper address byte of the i/o window, compared with adr[31:24]
`define MPU_IO_BASE 8'hFE

// block codes in adr[15:12]
`define MPU_PIT_BLOCK 4'h0
`define MPU_PIC_BLOCK 4'h1

// ==========================================================
// block sizes
// ==========================================================

// interval timer channels
`define MPU_PIT_CHANNELS 4

// interrupt sources, source 0 is reserved and never raises
`define MPU_PIC_SOURCES 32

// first source used by the timer
// channel k raises source MPU_PIT_SRC_BASE+k
`define MPU_PIT_SRC_BASE 28

`endif
